/* design/capture_pkg.sv */
package capture_pkg;

    // Address width of the sample memory, which sets the window length
    localparam int capture_addr_width = 6;

    // Samples in one captured window, always the full memory
    localparam int capture_depth = 1 << capture_addr_width;

    // Width of one sample word
    localparam int sample_width = 32;

    // Stream routing fields carried alongside the samples
    localparam int dest_width = 16;
    localparam int user_width = 16;

    // One frozen window as handed from the capture side to the readout side.
    // The start address points at the oldest sample in the memory
    typedef struct packed {
        logic [capture_addr_width-1:0] start_addr;
        logic [dest_width-1:0]         dest;
        logic [user_width-1:0]         user;
    } capture_descriptor;

endpackage

/* design/capture_ram_if.sv */
interface capture_ram_if;

    import capture_pkg::*;

    // Write port, owned by the capture side
    logic                          we;
    logic [capture_addr_width-1:0] waddr;
    logic [sample_width-1:0]       wdata;

    // Read port, owned by the readout side; data follows re by one cycle
    logic                          re;
    logic [capture_addr_width-1:0] raddr;
    logic [sample_width-1:0]       rdata;

    modport writer (
        output we,
        output waddr,
        output wdata
    );

    modport reader (
        output re,
        output raddr,
        input  rdata
    );

    modport memory (
        input  we,
        input  waddr,
        input  wdata,
        input  re,
        input  raddr,
        output rdata
    );

endinterface

/* design/capture_memory.sv */
module capture_memory (
    input logic           clock,
    capture_ram_if.memory mem
);

    import capture_pkg::*;

    // One word per sample position of the circular window
    logic [sample_width-1:0] storage [capture_depth];

    // Write side, one sample per accepted input beat
    always_ff @(posedge clock) begin
        if (mem.we) begin
            storage[mem.waddr] <= mem.wdata;
        end
    end

    // Registered read, rdata holds its value between reads so the
    // readout side can rely on it for the cycle after re
    always_ff @(posedge clock) begin
        if (mem.re) begin
            mem.rdata <= storage[mem.raddr];
        end
    end

endmodule

/* design/capture_control.sv */
module capture_control (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic                                   enable,
    input  logic                                   trigger,
    input  logic [capture_pkg::capture_addr_width-1:0] trigger_point,
    input  logic [capture_pkg::sample_width-1:0]   in_data,
    input  logic [capture_pkg::dest_width-1:0]     in_dest,
    input  logic [capture_pkg::user_width-1:0]     in_user,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    output logic                                   full,
    capture_ram_if.writer                          ram,
    output logic                                   start,
    output capture_pkg::capture_descriptor         window,
    input  logic                                   done
);

    import capture_pkg::*;

    // Counters need one extra bit to hold the value capture_depth itself
    typedef logic [capture_addr_width:0] count_t;

    typedef enum logic [1:0] {
        st_filling,
        st_post_trigger,
        st_frozen
    } state_t;

    state_t                        state;
    logic [capture_addr_width-1:0] wr_ptr;
    count_t                        fill_count;
    count_t                        post_count;
    count_t                        post_target_q;
    logic [dest_width-1:0]         dest_q;
    logic [user_width-1:0]         user_q;

    logic   accept;
    logic   trigger_ok;
    count_t new_target;
    count_t target;
    count_t post_base;
    count_t post_next;
    logic   window_closes;

    assign full     = (state == st_frozen);
    assign in_ready = enable && !full;
    assign accept   = in_valid && in_ready;

    // A trigger counts only while filling and once enough history is stored
    assign trigger_ok = trigger && (state == st_filling) &&
                        (count_t'(trigger_point) <= fill_count);

    // Post-trigger samples still needed to complete the window
    assign new_target = count_t'(capture_depth) - count_t'(trigger_point);
    assign target     = (state == st_post_trigger) ? post_target_q : new_target;

    // The sample taken in the trigger cycle is already a post-trigger sample
    assign post_base = (state == st_post_trigger) ? post_count : '0;
    assign post_next = post_base + count_t'(accept);

    assign window_closes = (trigger_ok || (state == st_post_trigger)) &&
                           (post_next == target);

    assign ram.we    = accept;
    assign ram.waddr = wr_ptr;
    assign ram.wdata = in_data;

    // Once frozen the write pointer sits on the oldest stored sample
    assign window = '{start_addr: wr_ptr, dest: dest_q, user: user_q};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= st_filling;
            wr_ptr     <= '0;
            fill_count <= '0;
            post_count <= '0;
            start      <= 1'b0;
        end else begin
            start <= 1'b0;

            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (fill_count != count_t'(capture_depth)) begin
                    fill_count <= fill_count + 1'b1;
                end
            end

            case (state)
                st_filling: begin
                    if (trigger_ok) begin
                        post_count <= post_next;
                        start      <= window_closes;
                        state      <= window_closes ? st_frozen : st_post_trigger;
                    end
                end
                st_post_trigger: begin
                    if (accept) begin
                        post_count <= post_next;
                        if (window_closes) begin
                            state <= st_frozen;
                            start <= 1'b1;
                        end
                    end
                end
                st_frozen: begin
                    // Re-arm with an empty history when playback completes
                    if (done) begin
                        state      <= st_filling;
                        fill_count <= '0;
                    end
                end
                default: state <= st_filling;
            endcase
        end
    end

    // Routing fields and window length are taken from the trigger cycle
    always_ff @(posedge clock) begin
        if (trigger_ok) begin
            dest_q        <= in_dest;
            user_q        <= in_user;
            post_target_q <= new_target;
        end
    end

    // A window is frozen only once every memory word holds a sample of the
    // current capture
    a_frozen_window_filled : assert property (
        @(posedge clock) disable iff (!rst_n)
        full |-> (fill_count == count_t'(capture_depth))
    );

    // Only the readout side can release a frozen window
    a_full_falls_on_done : assert property (
        @(posedge clock) disable iff (!rst_n)
        $fell(full) |-> $past(done)
    );

endmodule

/* design/readout_streamer.sv */
module readout_streamer (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 start,
    input  capture_pkg::capture_descriptor       window,
    capture_ram_if.reader                        ram,
    output logic [capture_pkg::sample_width-1:0] out_data,
    output logic [capture_pkg::dest_width-1:0]   out_dest,
    output logic [capture_pkg::user_width-1:0]   out_user,
    output logic                                 out_last,
    output logic                                 out_valid,
    input  logic                                 out_ready,
    output logic                                 done
);

    import capture_pkg::*;

    localparam logic [capture_addr_width-1:0] last_index =
        capture_addr_width'(capture_depth - 1);

    // Read side state
    logic                          reading;
    logic [capture_addr_width-1:0] issue_count;
    logic [capture_addr_width-1:0] next_addr;
    logic [capture_addr_width-1:0] rd_addr;
    logic                          rd_pending;

    // Output side state
    logic                          skid_valid;
    logic [sample_width-1:0]       skid_data;
    logic [capture_addr_width-1:0] out_count;

    logic issue;
    logic pop;
    logic out_free;

    assign pop      = out_valid && out_ready;
    assign out_free = !out_valid || out_ready;

    // The first read goes out in the start cycle, straight from the descriptor.
    // Reads are only issued when the output stage can move, so at most one
    // read lands while the output is stalled and the skid register takes it
    assign issue   = (start || reading) && out_free;
    assign rd_addr = start ? window.start_addr : next_addr;

    assign ram.re    = issue;
    assign ram.raddr = rd_addr;

    // Routing fields stay constant for the whole frozen window
    assign out_dest = window.dest;
    assign out_user = window.user;

    assign out_last = out_valid && (out_count == last_index);
    assign done     = pop && out_last;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            reading     <= 1'b0;
            issue_count <= '0;
            rd_pending  <= 1'b0;
            out_valid   <= 1'b0;
            skid_valid  <= 1'b0;
            out_count   <= '0;
        end else begin
            rd_pending <= issue;

            if (issue) begin
                if (start) begin
                    reading     <= 1'b1;
                    issue_count <= capture_addr_width'(1);
                end else begin
                    issue_count <= issue_count + 1'b1;
                    if (issue_count == last_index) begin
                        reading <= 1'b0;
                    end
                end
            end

            // Beat counter wraps back to zero after the last beat
            if (pop) begin
                out_count <= out_count + 1'b1;
            end

            if (out_free) begin
                out_valid  <= skid_valid || rd_pending;
                skid_valid <= skid_valid && rd_pending;
            end else if (rd_pending) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            next_addr <= rd_addr + 1'b1;
        end

        // The skid entry is older than the word now arriving from the RAM
        if (out_free) begin
            out_data <= skid_valid ? skid_data : ram.rdata;
            if (skid_valid) begin
                skid_data <= ram.rdata;
            end
        end else if (rd_pending) begin
            skid_data <= ram.rdata;
        end
    end

    // A stalled beat stays on the bus unchanged until it is taken
    a_hold_under_stall : assert property (
        @(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

/* design/capture_buffer.sv */
module capture_buffer (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       enable,
    input  logic                                       trigger,
    input  logic [capture_pkg::capture_addr_width-1:0] trigger_point,
    input  logic [capture_pkg::sample_width-1:0]       in_data,
    input  logic [capture_pkg::dest_width-1:0]         in_dest,
    input  logic [capture_pkg::user_width-1:0]         in_user,
    input  logic                                       in_valid,
    output logic                                       in_ready,
    output logic [capture_pkg::sample_width-1:0]       out_data,
    output logic [capture_pkg::dest_width-1:0]         out_dest,
    output logic [capture_pkg::user_width-1:0]         out_user,
    output logic                                       out_last,
    output logic                                       out_valid,
    input  logic                                       out_ready,
    output logic                                       full
);

    import capture_pkg::*;

    capture_ram_if     ram ();
    capture_descriptor window;
    logic              start;
    logic              done;

    capture_memory u_memory (
        .clock (clock),
        .mem   (ram.memory)
    );

    // Records the stream and freezes the window after the trigger
    capture_control u_control (
        .clock         (clock),
        .rst_n         (rst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .in_data       (in_data),
        .in_dest       (in_dest),
        .in_user       (in_user),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .full          (full),
        .ram           (ram.writer),
        .start         (start),
        .window        (window),
        .done          (done)
    );

    // Plays the frozen window back oldest first
    readout_streamer u_streamer (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (start),
        .window    (window),
        .ram       (ram.reader),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_user  (out_user),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .done      (done)
    );

endmodule

/* bench/capture_buffer_tb.sv */
module capture_buffer_tb;

    import capture_pkg::*;

    localparam int clock_period    = 4;
    localparam int reset_cycles    = 10;
    // Worst case per window is pre-trigger fill, post-trigger fill and a stalled playback
    localparam int window_budget   = 4 * capture_depth;
    localparam int window_count    = 6;
    localparam int watchdog_cycles = 4 * window_count * window_budget + reset_cycles;

    logic                          clock;
    logic                          rst_n;
    logic                          enable;
    logic                          trigger;
    logic [capture_addr_width-1:0] trigger_point;
    logic [sample_width-1:0]       in_data;
    logic [dest_width-1:0]         in_dest;
    logic [user_width-1:0]         in_user;
    logic                          in_valid;
    logic                          in_ready;
    logic [sample_width-1:0]       out_data;
    logic [dest_width-1:0]         out_dest;
    logic [user_width-1:0]         out_user;
    logic                          out_last;
    logic                          out_valid;
    logic                          out_ready;
    logic                          full;

    // Reference model state
    logic [sample_width-1:0] history [$];
    logic [sample_width-1:0] window_exp [$];
    logic [dest_width-1:0]   dest_m;
    logic [user_width-1:0]   user_m;
    int                      fill_m;
    int                      post_m;
    int                      target_m;
    int                      beats;
    int                      age;
    bit                      pending_m;
    bit                      frozen_m;
    int                      windows_done;

    // Stimulus state
    logic [sample_width-1:0] next_sample;
    bit                      random_ready;
    bit                      ready_held;

    capture_buffer UUT (
        .clock         (clock),
        .rst_n         (rst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .in_data       (in_data),
        .in_dest       (in_dest),
        .in_user       (in_user),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_data      (out_data),
        .out_dest      (out_dest),
        .out_user      (out_user),
        .out_last      (out_last),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .full          (full)
    );

    always #(clock_period / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping after the first error");
        end
    endtask

    // Monitor runs on the falling edge, where every port is settled and shows
    // exactly what the next rising edge will act on
    always @(negedge clock) begin : monitor
        bit acc;
        bit trig_ok;
        bit rearm;
        if (rst_n) begin
            check_value("full", full, frozen_m);
            check_value("in_ready", in_ready, enable && !frozen_m);
            rearm = 0;

            if (frozen_m) begin
                age++;
                if (beats == 0 && age < 2) begin
                    check_value("out_valid", out_valid, 1'b0);
                end else if (ready_held || beats == 0) begin
                    check_value("out_valid", out_valid, 1'b1);
                end
                if (out_valid) begin
                    check_value("out_data", out_data, window_exp[beats]);
                    check_value("out_dest", out_dest, dest_m);
                    check_value("out_user", out_user, user_m);
                    check_value("out_last", out_last, beats == capture_depth - 1);
                    if (out_ready) begin
                        beats++;
                        rearm = (beats == capture_depth);
                    end
                end
            end else begin
                check_value("out_valid", out_valid, 1'b0);
                check_value("out_last", out_last, 1'b0);
            end

            acc     = in_valid && enable && !frozen_m;
            trig_ok = trigger && !frozen_m && !pending_m && (int'(trigger_point) <= fill_m);
            if (acc) begin
                history.push_back(in_data);
                if (history.size() > capture_depth) begin
                    void'(history.pop_front());
                end
            end
            if (trig_ok) begin
                pending_m = 1;
                post_m    = 0;
                target_m  = capture_depth - int'(trigger_point);
                dest_m    = in_dest;
                user_m    = in_user;
            end
            if (pending_m && acc) post_m++;
            if (pending_m && post_m == target_m) begin
                pending_m  = 0;
                frozen_m   = 1;
                window_exp = history;
                age        = -1;
                beats      = 0;
            end
            if (acc && fill_m < capture_depth) fill_m++;

            // The last beat is taken on the coming edge, which also re-arms
            if (rearm) begin
                frozen_m = 0;
                fill_m   = 0;
                beats    = 0;
                windows_done++;
            end
        end
    end

    // Each step drives a fresh sample with its own routing fields
    task automatic step(input bit trig);
        @(posedge clock);
        in_data <= next_sample;
        in_dest <= next_sample[15:0] ^ 16'h3c3c;
        in_user <= next_sample[15:0] + 16'h0101;
        trigger <= trig;
        if (random_ready) begin
            out_ready <= ($urandom % 3) != 0;
        end
        next_sample = next_sample + 1;
    endtask

    task automatic configure(input int tp, input bit en, input bit rand_ready);
        trigger_point <= tp[capture_addr_width-1:0];
        enable        <= en;
        in_valid      <= 1'b1;
        random_ready  = rand_ready;
        ready_held    = !rand_ready;
        if (!rand_ready) begin
            out_ready <= 1'b1;
        end
    endtask

    task automatic run_until_rearm(input int trig_step);
        int done_before;
        int n;
        done_before = windows_done;
        n = 0;
        while (windows_done == done_before) begin
            step(n == trig_step);
            n++;
        end
    endtask

    task automatic test_pretrigger_order();
        configure(10, 1'b1, 1'b0);
        repeat (20) step(1'b0);
        run_until_rearm(0);
    endtask

    task automatic test_routing_fields();
        configure(5, 1'b1, 1'b0);
        repeat (12) step(1'b0);
        run_until_rearm(0);
    endtask

    task automatic test_back_pressure();
        configure(32, 1'b1, 1'b1);
        repeat (40) step(1'b0);
        run_until_rearm(0);
    endtask

    task automatic test_ignored_triggers();
        configure(20, 1'b1, 1'b0);
        repeat (5) step(1'b0);
        // Too few samples stored yet, so this one is dropped
        step(1'b1);
        configure(20, 1'b0, 1'b0);
        repeat (8) step(1'b0);
        configure(20, 1'b1, 1'b0);
        repeat (20) step(1'b0);
        step(1'b1);
        repeat (3) step(1'b0);
        step(1'b1);
        // A further trigger lands while the window is frozen
        run_until_rearm(60);
    endtask

    task automatic test_rearm_extremes();
        configure(0, 1'b1, 1'b0);
        run_until_rearm(0);
        configure(63, 1'b1, 1'b0);
        repeat (63) step(1'b0);
        run_until_rearm(0);
    endtask

    initial begin
        void'($urandom(91));
        clock         = 1'b0;
        rst_n         = 1'b0;
        enable        = 1'b0;
        trigger       = 1'b0;
        trigger_point = '0;
        in_data       = '0;
        in_dest       = '0;
        in_user       = '0;
        in_valid      = 1'b0;
        out_ready     = 1'b0;
        next_sample   = 32'h0000_1000;
        random_ready  = 0;
        ready_held    = 1;
        fill_m        = 0;
        pending_m     = 0;
        frozen_m      = 0;
        beats         = 0;
        windows_done  = 0;

        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;

        test_pretrigger_order();
        test_routing_fields();
        test_back_pressure();
        test_ignored_triggers();
        test_rearm_extremes();

        repeat (4) @(posedge clock);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * clock_period);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* src.f */
design/capture_pkg.sv
design/capture_ram_if.sv
design/capture_memory.sv
design/capture_control.sv
design/readout_streamer.sv
design/capture_buffer.sv
bench/capture_buffer_tb.sv

/* Bender.yml */
package:
  name: capture_buffer

sources:
  - design/capture_pkg.sv
  - design/capture_ram_if.sv
  - design/capture_memory.sv
  - design/capture_control.sv
  - design/readout_streamer.sv
  - design/capture_buffer.sv
  - target: test
    files:
      - bench/capture_buffer_tb.sv
